// ==== game_ctrl.f ====
game_pkg.sv
mouse_sync.sv
delay_timer.sv
game_round.sv
game_control_fsm.sv
game_status_wb.sv
game_ctrl_top.sv
game_ctrl_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := game_ctrl_tb
RTL_TOP    := game_ctrl_top
FILELIST   := game_ctrl.f
TB_FILE    := game_ctrl_tb.sv
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timescale 1ns/1ps
BUILD_DIR  := obj_dir

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(filter-out $(TB_FILE),$(SOURCES))

clean:
	rm -rf $(BUILD_DIR)

// ==== game_ctrl_tb.sv ====
// game control testbench
// drives mouse clicks and Wishbone accesses into the game control core
// and checks mode, score, won and games played against a click model
`timescale 1ns/1ps

module game_ctrl_tb;

    typedef logic [game_pkg::POS_W-1:0] pos_t;

    // both start delays and both rounds, plus slack for clicks and bus cycles
    localparam int WATCHDOG_CYCLES = 10 + 2 * (game_pkg::DELAY_CYCLES + 2) +
                                     2 * game_pkg::ROUND_CYCLES + 1000;

    logic                               clk;
    logic                               rst;
    game_pkg::mouse_t                   mouse;
    game_pkg::game_mode_t               mode;
    logic                               wb_cyc;
    logic                               wb_stb;
    logic                               wb_we;
    logic [game_pkg::WB_ADDR_W-1:0]     wb_adr;
    logic [31:0]                        wb_dat_w;
    logic [31:0]                        wb_dat_r;
    logic                               wb_ack;

    logic [15:0] lfsr     = 16'd62134;
    int          cycles   = 0;
    logic        ack_prev = 1'b0;

    game_ctrl_top UUT (
        .clk      (clk),
        .rst      (rst),
        .mouse    (mouse),
        .mode     (mode),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // free-running cycle count, read on falling edges
    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                             input string name);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t: %s got %0h expected %0h",
                                $time, name, got, exp));
        end
    endtask

    // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic int rand_bits(input int n);
        int   v;
        int   i;
        logic fb;
        v = 0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // reference hit test, far edges exclusive
    function automatic logic in_area(input pos_t x, input pos_t y, input pos_t rx,
                                     input pos_t ry, input pos_t rw, input pos_t rh);
        return (x >= rx) && (x < rx + rw) && (y >= ry) && (y < ry + rh);
    endfunction

    // status word at address 0
    function automatic logic [31:0] mode_word(input logic won, input logic [2:0] m);
        return {28'd0, won, m};
    endfunction

    // press at (x, y) for hold cycles, then release for gap cycles
    task automatic send_click(input pos_t x, input pos_t y, input int hold, input int gap);
        mouse.xpos = x;
        mouse.ypos = y;
        mouse.left = 1'b1;
        repeat (hold) @(negedge clk);
        mouse.left = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // half the clicks aimed at the target, the rest anywhere
    task automatic play_click(inout int hits);
        pos_t x;
        pos_t y;
        if (rand_bits(1) == 1) begin
            x = game_pkg::TARGET_XPOS + pos_t'(rand_bits(6));
            y = game_pkg::TARGET_YPOS + pos_t'(rand_bits(6));
        end else begin
            x = pos_t'(rand_bits(10));
            y = pos_t'(rand_bits(10));
        end
        if (in_area(x, y, game_pkg::TARGET_XPOS, game_pkg::TARGET_YPOS,
                    game_pkg::TARGET_WIDTH, game_pkg::TARGET_HEIGHT)) begin
            hits = hits + 1;
        end
        send_click(x, y, 1 + rand_bits(2), 1 + rand_bits(3));
    endtask

    task automatic wait_mode(input logic [2:0] m, input int limit);
        int n;
        n = 0;
        while (mode !== m) begin
            @(negedge clk);
            n = n + 1;
            if (n > limit) begin
                abort_run($sformatf("mode never reached %b within %0d cycles", m, limit));
            end
        end
    endtask

    // click the start button, game_enable due DELAY_CYCLES+2 cycles later
    // start screen stays up until then
    task automatic start_round();
        int k;
        mouse.xpos = game_pkg::START_XPOS + pos_t'(rand_bits(7));
        mouse.ypos = game_pkg::START_YPOS + pos_t'(rand_bits(5));
        mouse.left = 1'b1;
        for (k = 1; k <= game_pkg::DELAY_CYCLES + 2; k++) begin
            @(negedge clk);
            mouse.left = 1'b0;
            check_val({29'd0, mode},
                      (k == game_pkg::DELAY_CYCLES + 2) ? 32'h2 : 32'h4, "mode");
        end
    endtask

    // one Wishbone classic cycle, stb held through the ack cycle
    task automatic wb_access(input logic we, input logic [1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n        = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack) begin
            n = n + 1;
            if (n > 4) begin
                abort_run("Wishbone slave never acknowledged the request");
            end
            @(negedge clk);
        end
        rdata  = wb_dat_r;
        // ack sampled on the next edge, request released after it
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
    endtask

    task automatic wb_check(input logic [1:0] adr, input logic [31:0] exp, input string name);
        logic [31:0] rd;
        wb_access(1'b0, adr, 32'd0, rd);
        check_val(rd, exp, name);
    endtask

    // ------------------------------------------------------------------------
    // ack monitor and watchdog
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            check_val(32'(ack_prev && wb_ack), 32'd0, "wb_ack");
        end
        ack_prev = wb_ack;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired, the run took longer than all tests allow");
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        pos_t        x;
        pos_t        y;
        int          hits;
        int          t0;
        int          a;
        int          c;
        logic [31:0] rd;
        rst      = 1'b1;
        mouse    = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // after reset
        check_val({29'd0, mode}, 32'h4, "mode");
        wb_check(2'd0, mode_word(1'b0, 3'b100), "status");
        wb_check(2'd1, 32'd0, "score");
        wb_check(2'd2, 32'd0, "games_played");

        // clicks off the start button are lost
        for (c = 0; c < 6; c++) begin
            x = pos_t'(rand_bits(10));
            y = pos_t'(rand_bits(10));
            if (in_area(x, y, game_pkg::START_XPOS, game_pkg::START_YPOS,
                        game_pkg::START_WIDTH, game_pkg::AREA_HEIGHT)) begin
                y = '0;
            end
            send_click(x, y, 1 + rand_bits(2), 3);
            check_val({29'd0, mode}, 32'h4, "mode");
        end
        start_round();

        // winning round, stop clicking once the goal is predicted
        hits = 0;
        while (hits < game_pkg::TARGET_HITS) begin
            play_click(hits);
        end
        wait_mode(3'b001, 10);
        wb_check(2'd0, mode_word(1'b1, 3'b001), "status");
        wb_check(2'd1, hits, "score");

        // game over, any click leaves it, result held
        send_click(pos_t'(rand_bits(10)), pos_t'(rand_bits(10)), 1, 2);
        wait_mode(3'b100, 5);
        wb_check(2'd0, mode_word(1'b1, 3'b100), "status");
        wb_check(2'd1, hits, "score");

        // second round runs out of time
        start_round();
        t0   = cycles;
        hits = 0;
        for (c = 0; c < 6 && hits < game_pkg::TARGET_HITS - 1; c++) begin
            play_click(hits);
        end
        wait_mode(3'b001, game_pkg::ROUND_CYCLES + 10);
        if (cycles - t0 < game_pkg::ROUND_CYCLES ||
            cycles - t0 > game_pkg::ROUND_CYCLES + 4) begin
            abort_run($sformatf("ERROR at %0t: round lasted %0d cycles, expected about %0d",
                                $time, cycles - t0, game_pkg::ROUND_CYCLES));
        end
        wb_check(2'd0, mode_word(1'b0, 3'b001), "status");
        wb_check(2'd1, hits, "score");
        wb_check(2'd2, 32'd2, "games_played");

        // writes are acknowledged and dropped
        for (a = 0; a < 4; a++) begin
            wb_access(1'b1, 2'(a), 32'(rand_bits(16)), rd);
        end
        wb_check(2'd0, mode_word(1'b0, 3'b001), "status");
        wb_check(2'd1, hits, "score");
        wb_check(2'd2, 32'd2, "games_played");
        wb_check(2'd3, 32'd0, "unused");

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== game_ctrl_top.sv ====
// game control top level
// mouse register, game-control FSM, start delay timer, round scoring
// and the Wishbone status port
`timescale 1ns/1ps

module game_ctrl_top (
    input  logic                            clk,
    input  logic                            rst,
    input  game_pkg::mouse_t                 mouse,
    output game_pkg::game_mode_t             mode,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [game_pkg::WB_ADDR_W-1:0]  wb_adr,
    input  logic [31:0]                     wb_dat_w,
    output logic [31:0]                     wb_dat_r,
    output logic                            wb_ack
);

    game_pkg::mouse_t        mouse_q;
    logic                    click;
    logic                    start_delay;
    logic                    delay_done;
    logic                    round_over;
    game_pkg::round_result_t result;

    // ------------------------------------------------------------------------
    // mouse and control
    // ------------------------------------------------------------------------
    mouse_sync u_mouse_sync (
        .clk     (clk),
        .rst     (rst),
        .mouse   (mouse),
        .mouse_q (mouse_q),
        .click   (click)
    );

    game_control_fsm u_game_control_fsm (
        .clk         (clk),
        .rst         (rst),
        .mouse_q     (mouse_q),
        .click       (click),
        .delay_done  (delay_done),
        .round_over  (round_over),
        .start_delay (start_delay),
        .mode        (mode)
    );

    delay_timer u_delay_timer (
        .clk         (clk),
        .rst         (rst),
        .start_delay (start_delay),
        .delay_done  (delay_done)
    );

    // ------------------------------------------------------------------------
    // round scoring and status port
    // ------------------------------------------------------------------------
    game_round u_game_round (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .mouse_q    (mouse_q),
        .click      (click),
        .round_over (round_over),
        .result     (result)
    );

    game_status_wb u_game_status_wb (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .result     (result),
        .round_over (round_over),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

endmodule

// ==== game_status_wb.sv ====
// game status registers on a Wishbone classic slave
// read-only view of mode, result and the games-played count
// writes are acknowledged and dropped
`timescale 1ns/1ps

module game_status_wb (
    input  logic                            clk,
    input  logic                            rst,
    input  game_pkg::game_mode_t             mode,
    input  game_pkg::round_result_t          result,
    input  logic                            round_over,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [game_pkg::WB_ADDR_W-1:0]  wb_adr,
    input  logic [31:0]                     wb_dat_w,
    output logic [31:0]                     wb_dat_r,
    output logic                            wb_ack
);

    logic [game_pkg::COUNT_W-1:0] games_played;
    logic [31:0]                  rd_data;

    // finished rounds, wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            games_played <= '0;
        end else if (round_over) begin
            games_played <= games_played + game_pkg::COUNT_W'(1);
        end
    end

    // ------------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            2'd0:    rd_data[3:0] = {result.won, mode};
            2'd1:    rd_data[game_pkg::SCORE_W-1:0] = result.score;
            2'd2:    rd_data[game_pkg::COUNT_W-1:0] = games_played;
            default: rd_data = '0;
        endcase
    end

    // single ack one clock after the request, then released
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    // write cycles return zero
    always_ff @(posedge clk) begin
        wb_dat_r <= wb_we ? '0 : rd_data;
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_ack_in_cycle : assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("game_status_wb: ack outside a bus cycle");

    // master must hold clean write data until ack
    a_wdata_known : assert property (
        @(posedge clk) disable iff (rst)
        (wb_cyc && wb_stb && wb_we) |-> !$isunknown(wb_dat_w)
    ) else $error("game_status_wb: unknown write data");

endmodule

// ==== game_control_fsm.sv ====
// game control FSM
// start screen, start delay, game running and game over, with one
// registered mode enable per state and the delay request to the timer
`timescale 1ns/1ps

module game_control_fsm (
    input  logic                clk,
    input  logic                rst,
    input  game_pkg::mouse_t     mouse_q,
    input  logic                click,
    input  logic                delay_done,
    input  logic                round_over,
    output logic                start_delay,
    output game_pkg::game_mode_t mode
);

    game_pkg::game_state_t state;
    game_pkg::game_state_t state_nxt;
    logic                  start_hit;

    // click on the start button
    assign start_hit = click &&
                       game_pkg::in_rect(mouse_q, game_pkg::START_XPOS, game_pkg::START_YPOS,
                                         game_pkg::START_WIDTH, game_pkg::AREA_HEIGHT);

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            game_pkg::START_SCREEN: begin
                if (start_hit) begin
                    state_nxt = game_pkg::DELAY_START;
                end
            end
            game_pkg::DELAY_START: begin
                if (delay_done) begin
                    state_nxt = game_pkg::GAME_RUNNING;
                end
            end
            game_pkg::GAME_RUNNING: begin
                if (round_over) begin
                    state_nxt = game_pkg::GAME_OVER;
                end
            end
            game_pkg::GAME_OVER: begin
                // any click, wherever it lands
                if (click) begin
                    state_nxt = game_pkg::START_SCREEN;
                end
            end
            default: state_nxt = game_pkg::START_SCREEN;
        endcase
    end

    // ------------------------------------------------------------------------
    // state and mode registers
    // ------------------------------------------------------------------------
    // mode decoded from the next state so it flips on the same edge
    // start screen stays up through the delay
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= game_pkg::START_SCREEN;
            mode        <= '{start_screen_enable: 1'b1, game_enable: 1'b0,
                             game_end_enable: 1'b0};
            start_delay <= 1'b0;
        end else begin
            state                    <= state_nxt;
            mode.start_screen_enable <= (state_nxt == game_pkg::START_SCREEN) ||
                                        (state_nxt == game_pkg::DELAY_START);
            mode.game_enable         <= (state_nxt == game_pkg::GAME_RUNNING);
            mode.game_end_enable     <= (state_nxt == game_pkg::GAME_OVER);
            start_delay              <= (state_nxt == game_pkg::DELAY_START);
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    // exactly one enable in every state
    a_mode_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot(mode)
    ) else $error("game_control_fsm: mode not one-hot");

endmodule

// ==== game_round.sv ====
// game round
// scores clicks on the target rectangle while the game runs, times
// the round and reports its end with the final score and won flag
`timescale 1ns/1ps

module game_round (
    input  logic                   clk,
    input  logic                   rst,
    input  game_pkg::game_mode_t    mode,
    input  game_pkg::mouse_t        mouse_q,
    input  logic                   click,
    output logic                   round_over,
    output game_pkg::round_result_t result
);

    logic                         game_enable_q;
    logic                         round_start;
    logic                         hit_click;
    logic                         ended;
    logic [game_pkg::ROUND_W-1:0] timer;
    logic [game_pkg::SCORE_W-1:0] score;
    logic                         won;

    // first cycle of game_enable
    assign round_start = mode.game_enable & ~game_enable_q;

    // click on the target while the game runs
    assign hit_click = click && mode.game_enable &&
                       game_pkg::in_rect(mouse_q, game_pkg::TARGET_XPOS,
                                         game_pkg::TARGET_YPOS, game_pkg::TARGET_WIDTH,
                                         game_pkg::TARGET_HEIGHT);

    // ------------------------------------------------------------------------
    // score, timer and end of round
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            game_enable_q <= 1'b0;
            ended         <= 1'b0;
            round_over    <= 1'b0;
            timer         <= '0;
            score         <= '0;
            won           <= 1'b0;
        end else begin
            game_enable_q <= mode.game_enable;
            round_over    <= 1'b0;
            if (round_start) begin
                // new round, a hit in this very cycle still counts
                ended <= 1'b0;
                timer <= '0;
                won   <= 1'b0;
                score <= hit_click ? game_pkg::SCORE_W'(1) : '0;
            end else if (mode.game_enable && !ended) begin
                timer <= timer + game_pkg::ROUND_W'(1);
                if (score == game_pkg::SCORE_W'(game_pkg::TARGET_HITS)) begin
                    // goal reached
                    round_over <= 1'b1;
                    won        <= 1'b1;
                    ended      <= 1'b1;
                end else if (timer == game_pkg::ROUND_W'(game_pkg::ROUND_CYCLES - 1)) begin
                    // out of time, score stays as is
                    round_over <= 1'b1;
                    ended      <= 1'b1;
                end else if (hit_click) begin
                    score <= score + game_pkg::SCORE_W'(1);
                end
            end
        end
    end

    // held through game over and the next start screen
    assign result.score = score;
    assign result.won   = won;

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_score_bound : assert property (
        @(posedge clk) disable iff (rst)
        score <= game_pkg::SCORE_W'(game_pkg::TARGET_HITS)
    ) else $error("game_round: score above TARGET_HITS");

endmodule

// ==== delay_timer.sv ====
// start delay timer
// counts clock cycles while the FSM holds its delay request and
// flags the end of the start delay
`timescale 1ns/1ps

module delay_timer (
    input  logic clk,
    input  logic rst,
    input  logic start_delay,
    output logic delay_done
);

    logic [game_pkg::DELAY_W-1:0] cnt;

    // held at zero whenever no delay is requested
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (!start_delay) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + game_pkg::DELAY_W'(1);
        end
    end

    // terminal count, high in the last cycle of the delay
    assign delay_done = (cnt == game_pkg::DELAY_W'(game_pkg::DELAY_CYCLES - 1));

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_done_in_delay : assert property (
        @(posedge clk) disable iff (rst)
        delay_done |-> start_delay
    ) else $error("delay_timer: delay_done without start_delay");

endmodule

// ==== mouse_sync.sv ====
// mouse input register
// samples the decoded mouse once per clock and turns the left
// button into a single-cycle click pulse on its rising edge
`timescale 1ns/1ps

module mouse_sync (
    input  logic            clk,
    input  logic            rst,
    input  game_pkg::mouse_t mouse,
    output game_pkg::mouse_t mouse_q,
    output logic            click
);

    // button level one cycle behind mouse_q
    logic left_prev;

    // ------------------------------------------------------------------------
    // input register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mouse_q   <= '0;
            left_prev <= 1'b0;
        end else begin
            mouse_q   <= mouse;
            left_prev <= mouse_q.left;
        end
    end

    // rising edge of the registered button
    // a held press gives one pulse only
    assign click = mouse_q.left & ~left_prev;

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    // pulse never stretches, even with a bouncing decoder upstream
    a_click_single : assert property (
        @(posedge clk) disable iff (rst)
        click |=> !click
    ) else $error("mouse_sync: click high in two consecutive cycles");

endmodule

// ==== game_pkg.sv ====
// game control package
// screen areas, timing and scoring constants, state encoding and the
// packed types shared by the mouse, game-control and status blocks
package game_pkg;

    // ------------------------------------------------------------------------
    // coordinates and screen areas
    // ------------------------------------------------------------------------
    localparam int POS_W = 12;

    // start button, far edges exclusive
    localparam logic [POS_W-1:0] START_XPOS  = 12'd448;
    localparam logic [POS_W-1:0] START_YPOS  = 12'd360;
    localparam logic [POS_W-1:0] START_WIDTH = 12'd128;
    localparam logic [POS_W-1:0] AREA_HEIGHT = 12'd48;

    // in-game target
    localparam logic [POS_W-1:0] TARGET_XPOS   = 12'd600;
    localparam logic [POS_W-1:0] TARGET_YPOS   = 12'd200;
    localparam logic [POS_W-1:0] TARGET_WIDTH  = 12'd64;
    localparam logic [POS_W-1:0] TARGET_HEIGHT = 12'd64;

    // ------------------------------------------------------------------------
    // timing and scoring
    // ------------------------------------------------------------------------
    localparam int DELAY_CYCLES = 64;
    localparam int ROUND_CYCLES = 2000;
    localparam int TARGET_HITS  = 5;
    localparam int SCORE_W      = 4;
    localparam int COUNT_W      = 8;
    localparam int WB_ADDR_W    = 2;
    // counter widths, delay counter reaches DELAY_CYCLES itself
    localparam int DELAY_W = $clog2(DELAY_CYCLES + 1);
    localparam int ROUND_W = $clog2(ROUND_CYCLES);

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [POS_W-1:0] xpos;
        logic [POS_W-1:0] ypos;
        logic             left;
    } mouse_t;

    // exactly one enable high at a time
    typedef struct packed {
        logic start_screen_enable;
        logic game_enable;
        logic game_end_enable;
    } game_mode_t;

    typedef struct packed {
        logic [SCORE_W-1:0] score;
        logic               won;
    } round_result_t;

    typedef enum logic [1:0] {
        START_SCREEN = 2'b00,
        DELAY_START  = 2'b01,
        GAME_RUNNING = 2'b10,
        GAME_OVER    = 2'b11
    } game_state_t;

    // rectangle hit test, far edges exclusive
    function automatic logic in_rect(mouse_t m, logic [POS_W-1:0] x, logic [POS_W-1:0] y,
                                     logic [POS_W-1:0] w, logic [POS_W-1:0] h);
        return (m.xpos >= x) && (m.xpos < x + w) && (m.ypos >= y) && (m.ypos < y + h);
    endfunction

endpackage
